// File: Bender.yml
package:
  name: core_ctrl

sources:
  - hw/ctrl_pkg.sv
  - hw/ctrl_exc_detect.sv
  - hw/ctrl_irq_arbiter.sv
  - hw/ctrl_fsm.sv
  - hw/ctrl_trap_out.sv
  - hw/core_ctrl.sv
  - target: test
    files:
      - verif/core_ctrl_tb.sv

// File: core_ctrl.f
hw/ctrl_pkg.sv
hw/ctrl_exc_detect.sv
hw/ctrl_irq_arbiter.sv
hw/ctrl_fsm.sv
hw/ctrl_trap_out.sv
hw/core_ctrl.sv
verif/core_ctrl_tb.sv

// File: hw/core_ctrl.sv
//////////////////////////////////////////////////////////////////////
// core controller top: exception detection, interrupt arbiter,
// controller FSM and trap cause output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_ctrl import ctrl_pkg::*; #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // fetch and decode
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  wfi_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  csr_pipe_flush_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  instr_fetch_err_plus2_i,
  input  logic                  instr_is_compressed_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [15:0]           instr_compressed_i,
  input  logic [XLEN-1:0]       pc_id_i,
  input  logic [XLEN-1:0]       lsu_addr_last_i,
  // LSU and privilege
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  input  priv_lvl_e             priv_mode_i,
  input  logic                  csr_mstatus_tw_i,
  input  logic                  csr_mstatus_mie_i,
  // interrupts
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_software_i,
  input  logic                  irq_timer_i,
  input  logic                  irq_external_i,
  input  logic [NumFastIrq-1:0] irq_fast_i,
  // branches and stalls
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  stall_id_i,
  input  logic                  lsu_req_in_id_i,
  // control outputs
  output logic                  ctrl_busy_o,
  output logic                  instr_valid_clear_o,
  output logic                  id_in_ready_o,
  output logic                  controller_run_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output pc_sel_e               pc_mux_o,
  output exc_pc_sel_e           exc_pc_mux_o,
  output exc_cause_e            exc_cause_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,
  output logic [XLEN-1:0]       csr_mtval_o,
  output logic                  flush_id_o,
  output logic                  nmi_mode_o
);

  exc_kind_e  exc_kind;
  exc_cause_e irq_cause;
  trap_sel_e  trap_sel;
  logic       exc_pending, special_req, fetch_err_now, in_flush;
  logic       mret, wfi, csr_flush, handle_irq, irq_is_nmi;

  ctrl_exc_detect i_exc_detect (
    .clk_i, .rst_ni, .instr_valid_i, .illegal_insn_i, .ecall_insn_i, .mret_insn_i,
    .wfi_insn_i, .ebrk_insn_i, .csr_pipe_flush_i, .instr_fetch_err_i, .load_err_i,
    .store_err_i, .priv_mode_i, .csr_mstatus_tw_i,
    .in_flush_i      (in_flush),
    .exc_kind_o      (exc_kind),
    .exc_pending_o   (exc_pending),
    .special_req_o   (special_req),
    .fetch_err_now_o (fetch_err_now),
    .mret_o          (mret),
    .wfi_o           (wfi),
    .csr_flush_o     (csr_flush)
  );

  ctrl_irq_arbiter #(.NumFastIrq(NumFastIrq)) i_irq_arbiter (
    .irq_pending_i, .irq_nm_i, .irq_software_i, .irq_timer_i, .irq_external_i,
    .irq_fast_i, .csr_mstatus_mie_i,
    .nmi_mode_i   (nmi_mode_o),
    .handle_irq_o (handle_irq),
    .irq_is_nmi_o (irq_is_nmi),
    .irq_cause_o  (irq_cause)
  );

  ctrl_fsm i_fsm (
    .clk_i, .rst_ni, .fetch_enable_i, .instr_valid_i,
    .exc_pending_i   (exc_pending),
    .special_req_i   (special_req),
    .fetch_err_now_i (fetch_err_now),
    .mret_i          (mret),
    .wfi_i           (wfi),
    .csr_flush_i     (csr_flush),
    .handle_irq_i    (handle_irq),
    .irq_is_nmi_i    (irq_is_nmi),
    .irq_nm_i, .irq_pending_i, .branch_set_i, .jump_set_i, .stall_id_i, .lsu_req_in_id_i,
    .ctrl_busy_o, .instr_valid_clear_o, .id_in_ready_o, .controller_run_o, .instr_req_o,
    .pc_set_o, .pc_mux_o, .exc_pc_mux_o, .csr_save_if_o, .csr_save_id_o,
    .csr_restore_mret_id_o, .csr_save_cause_o, .flush_id_o, .nmi_mode_o,
    .trap_sel_o      (trap_sel),
    .in_flush_o      (in_flush)
  );

  ctrl_trap_out i_trap_out (
    .trap_sel_i  (trap_sel),
    .exc_kind_i  (exc_kind),
    .irq_cause_i (irq_cause),
    .priv_mode_i, .pc_id_i, .instr_fetch_err_plus2_i, .instr_i, .instr_compressed_i,
    .instr_is_compressed_i, .lsu_addr_last_i, .exc_cause_o, .csr_mtval_o
  );

endmodule

// File: hw/ctrl_exc_detect.sv
//////////////////////////////////////////////////////////////////////
// exception detection: qualifies decoder and LSU flags, registers
// the requests and picks the highest-priority exception
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_exc_detect import ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  logic      illegal_insn_i,
  input  logic      ecall_insn_i,
  input  logic      mret_insn_i,
  input  logic      wfi_insn_i,
  input  logic      ebrk_insn_i,
  input  logic      csr_pipe_flush_i,
  input  logic      instr_fetch_err_i,
  input  logic      load_err_i,
  input  logic      store_err_i,
  input  priv_lvl_e priv_mode_i,
  input  logic      csr_mstatus_tw_i,
  input  logic      in_flush_i,
  output exc_kind_e exc_kind_o,
  output logic      exc_pending_o,
  output logic      special_req_o,
  output logic      fetch_err_now_o,
  output logic      mret_o,
  output logic      wfi_o,
  output logic      csr_flush_o
);

  logic ecall, ebrk, fetch_err, illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;

  // decoder flags only count with a valid instruction in ID
  assign ecall       = ecall_insn_i & instr_valid_i;
  assign ebrk        = ebrk_insn_i & instr_valid_i;
  assign fetch_err   = instr_fetch_err_i & instr_valid_i;
  assign mret_o      = mret_insn_i & instr_valid_i;
  assign wfi_o       = wfi_insn_i & instr_valid_i;
  assign csr_flush_o = csr_pipe_flush_i & instr_valid_i;

  // MRET below M-mode, and WFI with TW set, trap as illegal
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (mret_o | (csr_mstatus_tw_i & wfi_o));

  // requests drop while FLUSH handles them
  assign illegal_d = ((illegal_insn_i & instr_valid_i) | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall | ebrk | fetch_err | illegal_d) & ~in_flush_i;

  assign fetch_err_now_o = fetch_err & ~in_flush_i;
  assign special_req_o   = mret_o | wfi_o | csr_flush_o | exc_req_d | load_err_i | store_err_i;
  assign exc_pending_o   = exc_req_q | load_err_q | store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i & ~in_flush_i;
      store_err_q <= store_err_i & ~in_flush_i;
    end
  end

  // fixed priority, fetch error first, LSU errors last
  always_comb begin
    if (fetch_err) begin
      exc_kind_o = EXC_KIND_FETCH_ERR;
    end else if (illegal_q) begin
      exc_kind_o = EXC_KIND_ILLEGAL;
    end else if (ecall) begin
      exc_kind_o = EXC_KIND_ECALL;
    end else if (ebrk) begin
      exc_kind_o = EXC_KIND_EBREAK;
    end else if (store_err_q) begin
      exc_kind_o = EXC_KIND_STORE_ERR;
    end else if (load_err_q) begin
      exc_kind_o = EXC_KIND_LOAD_ERR;
    end else begin
      exc_kind_o = EXC_KIND_NONE;
    end
  end

endmodule

// File: hw/ctrl_fsm.sv
//////////////////////////////////////////////////////////////////////
// controller state machine with NMI mode, PC redirect,
// CSR save and restore strobes and IF/ID stall control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_fsm import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  logic        exc_pending_i,
  input  logic        special_req_i,
  input  logic        fetch_err_now_i,
  input  logic        mret_i,
  input  logic        wfi_i,
  input  logic        csr_flush_i,
  input  logic        handle_irq_i,
  input  logic        irq_is_nmi_i,
  input  logic        irq_nm_i,
  input  logic        irq_pending_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,
  input  logic        lsu_req_in_id_i,
  output logic        ctrl_busy_o,
  output logic        instr_valid_clear_o,
  output logic        id_in_ready_o,
  output logic        controller_run_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output logic        csr_save_if_o,
  output logic        csr_save_id_o,
  output logic        csr_restore_mret_id_o,
  output logic        csr_save_cause_o,
  output logic        flush_id_o,
  output logic        nmi_mode_o,
  output trap_sel_e   trap_sel_o,
  output logic        in_flush_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  logic        nmi_mode_q, nmi_mode_d;
  logic        stall, halt_if, retain_id;

  // multicycle op or outstanding LSU request in ID
  assign stall = stall_id_i | lsu_req_in_id_i;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d               = state_q;
    nmi_mode_d            = nmi_mode_q;
    instr_req_o           = 1'b1;
    ctrl_busy_o           = 1'b1;
    controller_run_o      = 1'b0;
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    csr_save_if_o         = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_save_cause_o      = 1'b0;
    trap_sel_o            = TRAP_NONE;
    halt_if               = 1'b0;
    retain_id             = 1'b0;
    flush_id_o            = 1'b0;

    unique case (state_q)
      RESET: begin
        // boot address stays selected until fetch is enabled
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id_o  = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id_o  = 1'b1;
        // any pending request wakes the core, even with MIE clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        if (!stall) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end
      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;
        // keep the instruction in ID so FLUSH can see what it was
        if (special_req_i) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        // a faulting fetch must not redirect
        if ((branch_set_i || jump_set_i) && !fetch_err_now_i) begin
          pc_set_o = 1'b1;
        end
        // interrupt waits for the current instruction, IF held meanwhile
        if (handle_irq_i && stall) begin
          halt_if = 1'b1;
        end
        if (handle_irq_i && !stall && !special_req_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          trap_sel_o       = TRAP_IRQ;
          if (irq_is_nmi_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end
      FLUSH: begin
        halt_if    = 1'b1;
        flush_id_o = 1'b1;
        state_d    = DECODE;
        if (exc_pending_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_cause_o = 1'b1;
          trap_sel_o       = TRAP_EXC;
        end else if (mret_i) begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
          nmi_mode_d            = 1'b0;
        end else if (wfi_i) begin
          state_d = WAIT_SLEEP;
        end else if (csr_flush_i && handle_irq_i) begin
          // CSR writes may just have enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // mepc always comes from IF here, ID path unused without writeback
  assign csr_save_id_o = 1'b0;

  assign id_in_ready_o       = ~stall & ~halt_if & ~retain_id;
  assign instr_valid_clear_o = (instr_valid_i & ~(stall | retain_id)) | flush_id_o;
  assign in_flush_o          = (state_q == FLUSH);
  assign nmi_mode_o          = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// File: hw/ctrl_irq_arbiter.sv
//////////////////////////////////////////////////////////////////////
// interrupt arbitration: take decision and winning cause code
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_irq_arbiter import ctrl_pkg::*; #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_software_i,
  input  logic                  irq_timer_i,
  input  logic                  irq_external_i,
  input  logic [NumFastIrq-1:0] irq_fast_i,
  input  logic                  csr_mstatus_mie_i,
  input  logic                  nmi_mode_i,
  output logic                  handle_irq_o,
  output logic                  irq_is_nmi_o,
  output exc_cause_e            irq_cause_o
);

  localparam int unsigned IdW = $clog2(NUM_FAST_IRQ_MAX + 1);

  logic [IdW-1:0] fast_id;

  // nothing nests inside an NMI handler
  assign handle_irq_o = ~nmi_mode_i & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));
  assign irq_is_nmi_o = ~nmi_mode_i & irq_nm_i;

  // ascending scan, so the highest set id wins
  always_comb begin
    fast_id = '0;
    for (int unsigned i = 0; i < NumFastIrq; i++) begin
      if (irq_fast_i[i]) begin
        fast_id = IdW'(i);
      end
    end
  end

  always_comb begin
    irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (|irq_fast_i) begin
      // fast n lands at 48 + n
      irq_cause_o = exc_cause_e'(EXC_CAUSE_IRQ_FAST_0 + 6'(fast_id));
    end else if (irq_external_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_software_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irq_timer_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

// File: hw/ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths and enumerations for the core controller
// privilege, trap cause, exception kind, PC and trap selects
//////////////////////////////////////////////////////////////////////

package ctrl_pkg;

  // data and address width
  parameter int unsigned XLEN = 32;

  // cause encoding leaves room for fast ids 0..14 below the NMI code
  parameter int unsigned NUM_FAST_IRQ_MAX = 15;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mcause values, bit 5 marks an interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'd0,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'd35,
    EXC_CAUSE_IRQ_TIMER_M        = 6'd39,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'd43,
    EXC_CAUSE_IRQ_FAST_0         = 6'd48,
    EXC_CAUSE_IRQ_NM             = 6'd63
  } exc_cause_e;

  // winner of the synchronous exception priority chain
  typedef enum logic [2:0] {
    EXC_KIND_NONE,
    EXC_KIND_FETCH_ERR,
    EXC_KIND_ILLEGAL,
    EXC_KIND_ECALL,
    EXC_KIND_EBREAK,
    EXC_KIND_STORE_ERR,
    EXC_KIND_LOAD_ERR
  } exc_kind_e;

  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_EXC,
    TRAP_IRQ
  } trap_sel_e;

endpackage

// File: hw/ctrl_trap_out.sv
//////////////////////////////////////////////////////////////////////
// trap cause and mtval for the trap the FSM selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_trap_out import ctrl_pkg::*; (
  input  trap_sel_e        trap_sel_i,
  input  exc_kind_e        exc_kind_i,
  input  exc_cause_e       irq_cause_i,
  input  priv_lvl_e        priv_mode_i,
  input  logic [XLEN-1:0]  pc_id_i,
  input  logic             instr_fetch_err_plus2_i,
  input  logic [XLEN-1:0]  instr_i,
  input  logic [15:0]      instr_compressed_i,
  input  logic             instr_is_compressed_i,
  input  logic [XLEN-1:0]  lsu_addr_last_i,
  output exc_cause_e       exc_cause_o,
  output logic [XLEN-1:0]  csr_mtval_o
);

  exc_cause_e      exc_cause;
  logic [XLEN-1:0] exc_mtval;

  // cause and mtval per exception kind
  always_comb begin
    exc_cause = EXC_CAUSE_INSN_ADDR_MISA;
    exc_mtval = '0;
    unique case (exc_kind_i)
      EXC_KIND_FETCH_ERR: begin
        exc_cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
        // fault in the upper half of an unaligned fetch
        exc_mtval = instr_fetch_err_plus2_i ? (pc_id_i + XLEN'(2)) : pc_id_i;
      end
      EXC_KIND_ILLEGAL: begin
        exc_cause = EXC_CAUSE_ILLEGAL_INSN;
        exc_mtval = instr_is_compressed_i ? XLEN'(instr_compressed_i) : instr_i;
      end
      EXC_KIND_ECALL: begin
        exc_cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                  EXC_CAUSE_ECALL_UMODE;
      end
      EXC_KIND_EBREAK: begin
        exc_cause = EXC_CAUSE_BREAKPOINT;
      end
      EXC_KIND_STORE_ERR: begin
        exc_cause = EXC_CAUSE_STORE_ACCESS_FAULT;
        exc_mtval = lsu_addr_last_i;
      end
      EXC_KIND_LOAD_ERR: begin
        exc_cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
        exc_mtval = lsu_addr_last_i;
      end
      default: begin
        exc_cause = EXC_CAUSE_INSN_ADDR_MISA;
      end
    endcase
  end

  // interrupts leave mtval at zero
  assign exc_cause_o = (trap_sel_i == TRAP_IRQ) ? irq_cause_i :
                       (trap_sel_i == TRAP_EXC) ? exc_cause : EXC_CAUSE_INSN_ADDR_MISA;
  assign csr_mtval_o = (trap_sel_i == TRAP_EXC) ? exc_mtval : '0;

endmodule

// File: verif/core_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the core controller: boot, exception priority,
// interrupt arbitration, NMI and MRET, WFI sleep, branches, stalls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_ctrl_tb import ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_FAST   = 15;
  localparam int NUM_TESTS  = 6;
  // 400 cycles per test plus the reset phase
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 400 + 5;

  logic                clk_i, rst_ni, fetch_enable_i, instr_valid_i;
  logic                illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i;
  logic                csr_pipe_flush_i, instr_fetch_err_i, instr_fetch_err_plus2_i;
  logic                instr_is_compressed_i;
  logic [XLEN-1:0]     instr_i, pc_id_i, lsu_addr_last_i;
  logic [15:0]         instr_compressed_i;
  logic                load_err_i, store_err_i, csr_mstatus_tw_i, csr_mstatus_mie_i;
  priv_lvl_e           priv_mode_i;
  logic                irq_pending_i, irq_nm_i, irq_software_i, irq_timer_i, irq_external_i;
  logic [NUM_FAST-1:0] irq_fast_i;
  logic                branch_set_i, jump_set_i, stall_id_i, lsu_req_in_id_i;
  logic                ctrl_busy_o, instr_valid_clear_o, id_in_ready_o, controller_run_o;
  logic                instr_req_o, pc_set_o, csr_save_if_o, csr_save_id_o;
  logic                csr_restore_mret_id_o, csr_save_cause_o, flush_id_o, nmi_mode_o;
  pc_sel_e             pc_mux_o;
  exc_pc_sel_e         exc_pc_mux_o;
  exc_cause_e          exc_cause_o;
  logic [XLEN-1:0]     csr_mtval_o;

  int errors;
  int checks;

  core_ctrl #(.NumFastIrq(NUM_FAST)) i_core_ctrl (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  // ID must never accept a new instruction while stalled
  always @(posedge clk_i) begin
    if (rst_ni && (stall_id_i || lsu_req_in_id_i)) begin
      assert (!id_in_ready_o) else begin
        errors++;
        $display("id_in_ready_o was high while ID was stalled");
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic clear_inputs();
    instr_valid_i = 1'b0;
    illegal_insn_i = 1'b0;
    ecall_insn_i = 1'b0;
    mret_insn_i = 1'b0;
    wfi_insn_i = 1'b0;
    ebrk_insn_i = 1'b0;
    csr_pipe_flush_i = 1'b0;
    instr_fetch_err_i = 1'b0;
    instr_fetch_err_plus2_i = 1'b0;
    instr_is_compressed_i = 1'b0;
    instr_i = '0;
    instr_compressed_i = '0;
    pc_id_i = '0;
    lsu_addr_last_i = '0;
    load_err_i = 1'b0;
    store_err_i = 1'b0;
    priv_mode_i = PRIV_LVL_M;
    csr_mstatus_tw_i = 1'b0;
    csr_mstatus_mie_i = 1'b1;
    irq_pending_i = 1'b0;
    irq_nm_i = 1'b0;
    irq_software_i = 1'b0;
    irq_timer_i = 1'b0;
    irq_external_i = 1'b0;
    irq_fast_i = '0;
    branch_set_i = 1'b0;
    jump_set_i = 1'b0;
    stall_id_i = 1'b0;
    lsu_req_in_id_i = 1'b0;
  endtask

  // called on a falling edge, returns on the first falling edge in DECODE
  task automatic wait_decode();
    int n;
    n = 0;
    while (!controller_run_o && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    if (!controller_run_o) begin
      errors++;
      $display("controller did not return to DECODE in time");
    end
  endtask

  // priority: fetch error, illegal, ecall, ebreak, store, load
  function automatic logic [5:0] exc_cause_by_priority(input logic fe, ill, ec, eb, st, ld,
                                                       user);
    if (fe) return 6'd1;
    if (ill) return 6'd2;
    if (ec) return user ? 6'd8 : 6'd11;
    if (eb) return 6'd3;
    if (st) return 6'd7;
    return 6'd5;
  endfunction

  function automatic logic [31:0] mtval_by_kind(input logic fe, ill, ec, eb);
    if (fe) return instr_fetch_err_plus2_i ? pc_id_i + 32'd2 : pc_id_i;
    if (ill) return instr_is_compressed_i ? {16'h0, instr_compressed_i} : instr_i;
    if (ec || eb) return 32'h0;
    return lsu_addr_last_i;
  endfunction

  // NMI, then highest fast id, external, software, timer
  function automatic logic [5:0] irq_cause_by_priority(input logic nm,
                                                       input logic [NUM_FAST-1:0] fast,
                                                       input logic ext, sw);
    int top;
    top = -1;
    for (int i = 0; i < NUM_FAST; i++) begin
      if (fast[i]) top = i;
    end
    if (nm) return 6'd63;
    if (top >= 0) return 6'(48 + top);
    if (ext) return 6'd43;
    if (sw) return 6'd35;
    return 6'd39;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic boot_sequence();
    // still in RESET right after release
    check_val("boot_reset_req", 0, instr_req_o);
    check_val("boot_reset_pc_set", 1, pc_set_o);
    check_val("boot_reset_pc_mux", PC_BOOT, pc_mux_o);
    check_val("boot_reset_busy", 1, ctrl_busy_o);
    check_val("boot_reset_nmi", 0, nmi_mode_o);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    check_val("boot_set_req", 1, instr_req_o);
    check_val("boot_set_pc_set", 1, pc_set_o);
    check_val("boot_set_pc_mux", PC_BOOT, pc_mux_o);
    wait_decode();
  endtask

  task automatic exception_priority();
    logic fe, ill, ec, eb, ld, st, mr, wf, tw, user, ill_eff;
    for (int i = 0; i < 40; i++) begin
      fe = ($urandom % 5) == 0;
      ill = ($urandom % 4) == 0;
      ec = ($urandom % 3) == 0;
      eb = ($urandom % 3) == 0;
      ld = ($urandom % 3) == 0;
      st = ($urandom % 3) == 0;
      mr = ($urandom % 4) == 0;
      wf = ($urandom % 4) == 0;
      tw = $urandom % 2;
      user = $urandom % 2;
      // user-mode MRET and trapped WFI count as illegal
      ill_eff = ill | (user & (mr | (tw & wf)));
      if (!(fe | ill_eff | ec | eb | ld | st)) ec = 1'b1;
      instr_valid_i = 1'b1;
      instr_fetch_err_i = fe;
      illegal_insn_i = ill;
      ecall_insn_i = ec;
      ebrk_insn_i = eb;
      load_err_i = ld;
      store_err_i = st;
      mret_insn_i = mr;
      wfi_insn_i = wf;
      csr_mstatus_tw_i = tw;
      priv_mode_i = user ? PRIV_LVL_U : PRIV_LVL_M;
      instr_fetch_err_plus2_i = $urandom % 2;
      instr_is_compressed_i = $urandom % 2;
      instr_i = $urandom;
      instr_compressed_i = 16'($urandom);
      pc_id_i = $urandom;
      lsu_addr_last_i = $urandom;
      @(negedge clk_i);
      // FLUSH cycle
      check_val("exc_pc_set", 1, pc_set_o);
      check_val("exc_pc_mux", PC_EXC, pc_mux_o);
      check_val("exc_exc_pc_mux", EXC_PC_EXC, exc_pc_mux_o);
      check_val("exc_save_cause", 1, csr_save_cause_o);
      check_val("exc_flush_id", 1, flush_id_o);
      check_val("exc_valid_clear", 1, instr_valid_clear_o);
      check_val("exc_save_id", 0, csr_save_id_o);
      check_val("exc_cause", exc_cause_by_priority(fe, ill_eff, ec, eb, st, ld, user),
                exc_cause_o);
      check_val("exc_mtval", mtval_by_kind(fe, ill_eff, ec, eb), csr_mtval_o);
      clear_inputs();
      @(negedge clk_i);
      wait_decode();
    end
  endtask

  task automatic irq_arbitration();
    logic [NUM_FAST-1:0] fast;
    logic ext, sw, tm;
    for (int i = 0; i < 40; i++) begin
      fast = ($urandom % 2) ? NUM_FAST'($urandom) : '0;
      ext = $urandom % 2;
      sw = $urandom % 2;
      tm = $urandom % 2;
      if (!(|fast | ext | sw | tm)) tm = 1'b1;
      irq_fast_i = fast;
      irq_external_i = ext;
      irq_software_i = sw;
      irq_timer_i = tm;
      irq_pending_i = 1'b1;
      @(negedge clk_i);
      // IRQ_TAKEN cycle
      check_val("irq_pc_set", 1, pc_set_o);
      check_val("irq_save_if", 1, csr_save_if_o);
      check_val("irq_save_cause", 1, csr_save_cause_o);
      check_val("irq_pc_mux", PC_EXC, pc_mux_o);
      check_val("irq_exc_pc_mux", EXC_PC_IRQ, exc_pc_mux_o);
      check_val("irq_cause", irq_cause_by_priority(1'b0, fast, ext, sw), exc_cause_o);
      clear_inputs();
      @(negedge clk_i);
      wait_decode();
    end
    // masked by MIE
    csr_mstatus_mie_i = 1'b0;
    irq_pending_i = 1'b1;
    irq_external_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_val("irq_masked_save_if", 0, csr_save_if_o);
      check_val("irq_masked_run", 1, controller_run_o);
    end
    clear_inputs();
  endtask

  task automatic nmi_and_mret();
    irq_nm_i = 1'b1;
    @(negedge clk_i);
    check_val("nmi_save_if", 1, csr_save_if_o);
    check_val("nmi_cause", irq_cause_by_priority(1'b1, '0, 1'b0, 1'b0), exc_cause_o);
    // NMI is a level request, still high when IRQ_TAKEN ends
    @(negedge clk_i);
    clear_inputs();
    check_val("nmi_mode_set", 1, nmi_mode_o);
    // nothing is taken inside the NMI handler
    irq_pending_i = 1'b1;
    irq_external_i = 1'b1;
    irq_nm_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_val("nmi_nested_save_if", 0, csr_save_if_o);
    end
    clear_inputs();
    instr_valid_i = 1'b1;
    mret_insn_i = 1'b1;
    @(negedge clk_i);
    check_val("mret_pc_set", 1, pc_set_o);
    check_val("mret_pc_mux", PC_ERET, pc_mux_o);
    check_val("mret_restore", 1, csr_restore_mret_id_o);
    // MRET stays in ID through FLUSH
    @(negedge clk_i);
    clear_inputs();
    check_val("mret_nmi_clear", 0, nmi_mode_o);
    wait_decode();
  endtask

  task automatic wfi_sleep();
    instr_valid_i = 1'b1;
    wfi_insn_i = 1'b1;
    @(negedge clk_i);
    check_val("wfi_flush_id", 1, flush_id_o);
    // WFI stays in ID until FLUSH hands over to sleep
    @(negedge clk_i);
    clear_inputs();
    check_val("wfi_wait_busy", 0, ctrl_busy_o);
    repeat (3) begin
      @(negedge clk_i);
      check_val("wfi_sleep_busy", 0, ctrl_busy_o);
      check_val("wfi_sleep_req", 0, instr_req_o);
    end
    // wake without MIE, so no interrupt entry follows
    csr_mstatus_mie_i = 1'b0;
    irq_pending_i = 1'b1;
    @(negedge clk_i);
    check_val("wfi_wake_busy", 1, ctrl_busy_o);
    clear_inputs();
    wait_decode();
  endtask

  task automatic branch_and_stall();
    branch_set_i = 1'b1;
    #(CLK_PERIOD / 4);
    check_val("branch_pc_set", 1, pc_set_o);
    check_val("branch_pc_mux", PC_JUMP, pc_mux_o);
    @(negedge clk_i);
    clear_inputs();
    jump_set_i = 1'b1;
    #(CLK_PERIOD / 4);
    check_val("jump_pc_set", 1, pc_set_o);
    @(negedge clk_i);
    clear_inputs();
    // fetch error blocks the redirect and traps instead
    branch_set_i = 1'b1;
    instr_valid_i = 1'b1;
    instr_fetch_err_i = 1'b1;
    pc_id_i = $urandom;
    #(CLK_PERIOD / 4);
    check_val("branch_fetch_err_pc_set", 0, pc_set_o);
    @(negedge clk_i);
    check_val("branch_fetch_err_cause", 6'd1, exc_cause_o);
    check_val("branch_fetch_err_mtval", pc_id_i, csr_mtval_o);
    clear_inputs();
    @(negedge clk_i);
    wait_decode();
    for (int sel = 0; sel < 2; sel++) begin
      stall_id_i = (sel == 0);
      lsu_req_in_id_i = (sel == 1);
      instr_valid_i = 1'b1;
      irq_pending_i = 1'b1;
      irq_external_i = 1'b1;
      repeat (4) begin
        @(negedge clk_i);
        check_val("stall_id_ready", 0, id_in_ready_o);
        check_val("stall_valid_clear", 0, instr_valid_clear_o);
        check_val("stall_save_if", 0, csr_save_if_o);
        check_val("stall_run", 1, controller_run_o);
      end
      stall_id_i = 1'b0;
      lsu_req_in_id_i = 1'b0;
      @(negedge clk_i);
      check_val("stall_release_save_if", 1, csr_save_if_o);
      check_val("stall_release_cause", 6'd43, exc_cause_o);
      clear_inputs();
      @(negedge clk_i);
      wait_decode();
    end
  endtask

  initial begin
    int unsigned seed_dummy;
    seed_dummy = $urandom(32'hdf27);
    errors = 0;
    checks = 0;
    rst_ni = 1'b0;
    fetch_enable_i = 1'b0;
    clear_inputs();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    boot_sequence();
    exception_priority();
    irq_arbitration();
    nmi_and_mret();
    wfi_sleep();
    branch_and_stall();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
